//--- hw/mips_macros.svh
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// datapath width
`define MIPS_XLEN    32
// register index width, 32 architectural registers
`define MIPS_REG_IDX 5

// data memory, word addressed
`define DMEM_ADDR_W  7
`define DMEM_DEPTH   128

// fetch address after reset
`define RESET_PC     32'h0000_0000

`endif

//--- hw/mipsIsaPkg.sv
`include "mips_macros.svh"

package mipsIsaPkg;

  // ==================================================
  // major opcodes, instr[31:26]
  // ==================================================
  typedef enum logic [5:0] {
    opR    = 6'h00, // alu op picked by funct
    opJ    = 6'h02,
    opJal  = 6'h03,
    opBeq  = 6'h04,
    opAddi = 6'h08,
    opLw   = 6'h23,
    opSw   = 6'h2b
  } opcodeT;

  // r-type funct, instr[5:0]
  typedef enum logic [5:0] {
    fnAdd = 6'h20,
    fnSub = 6'h22,
    fnAnd = 6'h24,
    fnOr  = 6'h25,
    fnSlt = 6'h2a
  } functT;

  // ==================================================
  // instruction word layouts
  // ==================================================
  typedef struct packed {
    logic [`MIPS_REG_IDX-1:0] rs;
    logic [`MIPS_REG_IDX-1:0] rt;
    logic [`MIPS_REG_IDX-1:0] rd;
    logic [4:0]               shamt; // no shifts, never decoded
    functT                    funct;
  } rFieldsT;

  typedef struct packed {
    logic [`MIPS_REG_IDX-1:0] rs;
    logic [`MIPS_REG_IDX-1:0] rt;
    logic [15:0]              imm;
  } iFieldsT;

  // the 26 bits below the opcode, three views
  typedef union packed {
    rFieldsT     r;
    iFieldsT     i;
    logic [25:0] target; // j / jal word target
  } instrBodyT;

  typedef struct packed {
    opcodeT    opcode;
    instrBodyT body;
  } instrFieldsT; // 32 bits total

endpackage

//--- hw/mipsCtrlPkg.sv
package mipsCtrlPkg;

  // ==================================================
  // alu operations
  // ==================================================
  typedef enum logic [2:0] {
    aluAdd = 3'd0, // zero value, so an idle word adds
    aluSub = 3'd1,
    aluAnd = 3'd2,
    aluOr  = 3'd3,
    aluSlt = 3'd4  // signed compare
  } aluOpT;

  // ==================================================
  // control word, decoder to datapath
  // ==================================================
  typedef struct packed {
    logic  regDst;   // dest is rd, else rt
    logic  aluSrc;   // alu b is sign-extended imm
    logic  memToReg; // write back load data
    logic  regWrite;
    logic  memRead;
    logic  memWrite;
    logic  branch;   // beq, taken when alu zero
    logic  jump;
    logic  link;     // jal, r31 gets pc+4
    aluOpT aluOp;
  } ctrlWordT; // 12 bits

endpackage

//--- hw/dmemIf.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

// sram style port, all strobes active low
interface dmemIf;
  logic                    cen;   // chip select
  logic                    wen;   // write at next edge
  logic                    oen;   // drive rdata
  logic [`DMEM_ADDR_W-1:0] addr;  // word index
  logic [`MIPS_XLEN-1:0]   wdata;
  logic [`MIPS_XLEN-1:0]   rdata; // same-cycle read

  modport core (
    output cen, wen, oen, addr, wdata,
    input  rdata
  );

  modport mem (
    input  cen, wen, oen, addr, wdata,
    output rdata
  );
endinterface

//--- hw/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
  input  mipsIsaPkg::opcodeT    opcode,
  input  mipsIsaPkg::functT     funct,
  output mipsCtrlPkg::ctrlWordT ctrl
);
  import mipsIsaPkg::*;
  import mipsCtrlPkg::*;

  logic  rValid; // funct is one we know
  aluOpT rOp;

  // ==================================================
  // funct table, only looked at for r-type
  // ==================================================
  always_comb begin
    rValid = 1'b1;
    rOp    = aluAdd;
    case (funct)
      fnAdd:   rOp = aluAdd;
      fnSub:   rOp = aluSub;
      fnAnd:   rOp = aluAnd;
      fnOr:    rOp = aluOr;
      fnSlt:   rOp = aluSlt;
      default: rValid = 1'b0; // unknown funct, becomes a no-op
    endcase
  end

  // ==================================================
  // main decoder
  // ==================================================
  always_comb begin
    ctrl = '0; // everything off unless the opcode says so
    case (opcode)
      opR: begin
        if (rValid) begin
          ctrl.regDst   = 1'b1;
          ctrl.regWrite = 1'b1;
          ctrl.aluOp    = rOp;
        end
      end
      opAddi: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.regWrite = 1'b1; // rt <- rs + imm
      end
      opLw: begin
        ctrl.aluSrc   = 1'b1; // address = rs + imm
        ctrl.memToReg = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.memRead  = 1'b1;
      end
      opSw: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memWrite = 1'b1;
      end
      opBeq: begin
        ctrl.branch = 1'b1;
        ctrl.aluOp  = aluSub; // equal when difference is zero
      end
      opJ: ctrl.jump = 1'b1;
      opJal: begin
        ctrl.jump     = 1'b1;
        ctrl.link     = 1'b1;
        ctrl.regWrite = 1'b1; // r31 <- pc+4
      end
      default: ; // undefined opcode, idle word
    endcase
  end

endmodule

//--- hw/alu.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module alu (
  input  logic [`MIPS_XLEN-1:0] a,
  input  logic [`MIPS_XLEN-1:0] b,
  input  mipsCtrlPkg::aluOpT    op,
  output logic [`MIPS_XLEN-1:0] result,
  output logic                  zero
);
  import mipsCtrlPkg::*;

  logic lessThan; // signed a < b

  assign lessThan = $signed(a) < $signed(b);

  // ==================================================
  // operation select
  // ==================================================
  always_comb begin
    case (op)
      aluAdd: begin
        result = a + b; // addi, lw/sw address, add
      end
      aluSub: begin
        result = a - b; // sub, beq compare
      end
      aluAnd: begin
        result = a & b;
      end
      aluOr: begin
        result = a | b;
      end
      aluSlt: begin
        // 1 or 0 in bit 0
        result = {{(`MIPS_XLEN-1){1'b0}}, lessThan};
      end
      default: begin
        result = '0; // encodings 5..7 unused
      end
    endcase
  end

  // flag for every op, beq is the only consumer
  assign zero = (result == '0);

endmodule

//--- hw/regFile.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module regFile (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     we,
  input  logic [`MIPS_REG_IDX-1:0] waddr,
  input  logic [`MIPS_XLEN-1:0]    wdata,
  input  logic [`MIPS_REG_IDX-1:0] raddr1,
  input  logic [`MIPS_REG_IDX-1:0] raddr2,
  output logic [`MIPS_XLEN-1:0]    rdata1,
  output logic [`MIPS_XLEN-1:0]    rdata2
);

  localparam int NumRegs = 1 << `MIPS_REG_IDX;

  // r0 has no storage
  logic [`MIPS_XLEN-1:0] regs [1:NumRegs-1];

  // ==================================================
  // write port
  // ==================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < NumRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (waddr != '0)) begin // r0 writes dropped
      regs[waddr] <= wdata;
    end
  end

  // read ports, combinational
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- hw/dataMem.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module dataMem (
  input logic clk,
  dmemIf.mem  bus
);

  logic [`MIPS_XLEN-1:0] mem [0:`DMEM_DEPTH-1];

  logic selected; // cen asserted
  logic doWrite;
  logic doRead;

  // power-up contents
  initial begin
    for (int i = 0; i < `DMEM_DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  // ==================================================
  // strobe decode
  // ==================================================
  assign selected = !bus.cen;
  assign doWrite  = selected && !bus.wen;
  assign doRead   = selected && bus.wen && !bus.oen;

  // write lands at the edge
  always_ff @(posedge clk) begin
    if (doWrite) begin
      mem[bus.addr] <= bus.wdata;
    end
  end

  // async read, zero when not reading
  assign bus.rdata = doRead ? mem[bus.addr] : '0;

endmodule

//--- hw/mipsCore.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module mipsCore (
  input  logic                     clk,
  input  logic                     rst,
  output logic [`MIPS_XLEN-1:0]    instrAddr,
  input  logic [`MIPS_XLEN-1:0]    instr,
  output logic                     wbValid,
  output logic [`MIPS_REG_IDX-1:0] wbAddr,
  output logic [`MIPS_XLEN-1:0]    wbData,
  dmemIf.core                      dmem
);
  import mipsIsaPkg::*;
  import mipsCtrlPkg::*;

  localparam logic [`MIPS_REG_IDX-1:0] LinkReg = '1; // r31

  instrFieldsT fields;
  ctrlWordT    ctrl;

  logic [`MIPS_XLEN-1:0]    pcQ;
  logic [`MIPS_XLEN-1:0]    pcPlus4;
  logic [`MIPS_XLEN-1:0]    pcNext;
  logic [`MIPS_XLEN-1:0]    signExt;
  logic [`MIPS_XLEN-1:0]    branchTarget;
  logic [`MIPS_XLEN-1:0]    jumpTarget;
  logic                     branchTaken;
  logic [`MIPS_XLEN-1:0]    rsData;
  logic [`MIPS_XLEN-1:0]    rtData;
  logic [`MIPS_XLEN-1:0]    aluB;
  logic [`MIPS_XLEN-1:0]    aluResult;
  logic                     aluZero;
  logic [`MIPS_REG_IDX-1:0] destReg;
  logic [`MIPS_XLEN-1:0]    wbValue;
  logic                     regWe;

  assign fields = instrFieldsT'(instr);

  // ==================================================
  // decode and execute
  // ==================================================
  controlUnit ctrl_i (
    .opcode (fields.opcode),
    .funct  (fields.body.r.funct),
    .ctrl   (ctrl)
  );

  regFile rf_i (
    .clk    (clk),
    .rst    (rst),
    .we     (regWe),
    .waddr  (destReg),
    .wdata  (wbValue),
    .raddr1 (fields.body.i.rs),
    .raddr2 (fields.body.i.rt),
    .rdata1 (rsData),
    .rdata2 (rtData)
  );

  assign signExt = {{(`MIPS_XLEN-16){fields.body.i.imm[15]}}, fields.body.i.imm};
  assign aluB    = ctrl.aluSrc ? signExt : rtData; // imm for addi, lw, sw

  alu alu_i (
    .a      (rsData),
    .b      (aluB),
    .op     (ctrl.aluOp),
    .result (aluResult),
    .zero   (aluZero)
  );

  // ==================================================
  // next pc
  // ==================================================
  assign pcPlus4      = pcQ + `MIPS_XLEN'(4);
  assign branchTarget = pcPlus4 + {signExt[`MIPS_XLEN-3:0], 2'b00};
  assign jumpTarget   = {pcPlus4[`MIPS_XLEN-1:`MIPS_XLEN-4], fields.body.target, 2'b00};
  assign branchTaken  = ctrl.branch && aluZero;

  always_comb begin
    if (ctrl.jump) begin
      pcNext = jumpTarget;
    end else if (branchTaken) begin
      pcNext = branchTarget;
    end else begin
      pcNext = pcPlus4; // also undefined ops
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pcQ <= `RESET_PC;
    end else begin
      pcQ <= pcNext;
    end
  end

  assign instrAddr = rst ? `RESET_PC : pcQ; // vector shown for the whole reset

  // ==================================================
  // memory strobes, held off in reset
  // ==================================================
  assign dmem.cen   = rst || !(ctrl.memRead || ctrl.memWrite);
  assign dmem.wen   = rst || !ctrl.memWrite;
  assign dmem.oen   = !ctrl.memRead;
  assign dmem.addr  = aluResult[`DMEM_ADDR_W+1:2]; // byte address to word index
  assign dmem.wdata = rtData;

  // ==================================================
  // write back
  // ==================================================
  always_comb begin
    if (ctrl.link) begin
      destReg = LinkReg;
    end else if (ctrl.regDst) begin
      destReg = fields.body.r.rd;
    end else begin
      destReg = fields.body.i.rt;
    end
  end

  always_comb begin
    if (ctrl.link) begin
      wbValue = pcPlus4; // no delay slot
    end else if (ctrl.memToReg) begin
      wbValue = dmem.rdata;
    end else begin
      wbValue = aluResult;
    end
  end

  assign regWe   = ctrl.regWrite && (destReg != '0) && !rst;
  assign wbValid = regWe;
  assign wbAddr  = destReg;
  assign wbData  = wbValue;

endmodule

//--- hw/mipsSystem.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module mipsSystem (
  input  logic                     clk,
  input  logic                     rst,
  output logic [`MIPS_XLEN-1:0]    instrAddr, // fetch address, word aligned
  input  logic [`MIPS_XLEN-1:0]    instr,     // same-cycle instruction word
  output logic                     wbValid,
  output logic [`MIPS_REG_IDX-1:0] wbAddr,
  output logic [`MIPS_XLEN-1:0]    wbData
);

  // ==================================================
  // core to data memory
  // ==================================================
  dmemIf dmemBus ();

  mipsCore core_i (
    .clk       (clk),
    .rst       (rst),
    .instrAddr (instrAddr),
    .instr     (instr),
    .wbValid   (wbValid),
    .wbAddr    (wbAddr),
    .wbData    (wbData),
    .dmem      (dmemBus.core)
  );

  // 128 words
  dataMem dmem_i (
    .clk (clk),
    .bus (dmemBus.mem)
  );

endmodule

//--- test/mipsSystem_props.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module mipsSystem_props (
  input logic                     clk,
  input logic                     rst,
  input logic [`MIPS_XLEN-1:0]    instrAddr,
  input logic                     wbValid,
  input logic [`MIPS_REG_IDX-1:0] wbAddr,
  input logic                     cen,
  input logic                     wen
);

  int failCount = 0; // polled by the testbench at the end

  // ==================================================
  // data memory strobes
  // ==================================================
  writeNeedsSelect: assert property (@(posedge clk) !wen |-> !cen)
    else begin
      failCount++;
      $error("wen low while cen high");
    end

  // ==================================================
  // fetch and write back
  // ==================================================
  fetchAligned: assert property (@(posedge clk) instrAddr[1:0] == 2'b00)
    else begin
      failCount++;
      $error("instrAddr not word aligned");
    end

  noWriteToZero: assert property (@(posedge clk) wbValid |-> wbAddr != '0)
    else begin
      failCount++;
      $error("wbValid with wbAddr zero");
    end

  // first cycle out of reset fetches the vector
  resetVector: assert property (@(posedge clk) $fell(rst) |-> instrAddr == `RESET_PC)
    else begin
      failCount++;
      $error("instrAddr not at reset vector after reset");
    end

endmodule

//--- test/mipsSystem_tb.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module mipsSystem_tb;
  import mipsIsaPkg::*;

  localparam int MaxCycles = 200; // per program
  localparam int ImemWords = 256;

  logic                     clk;
  logic                     rst;
  logic [`MIPS_XLEN-1:0]    instrAddr;
  logic [`MIPS_XLEN-1:0]    instr;
  logic                     wbValid;
  logic [`MIPS_REG_IDX-1:0] wbAddr;
  logic [`MIPS_XLEN-1:0]    wbData;

  logic [31:0] imem [0:ImemWords-1];
  int          progLen;
  logic [31:0] endPc;
  string       curTest;
  logic [31:0] lfsrState = 32'd54;

  // reference model state
  logic [31:0] mPc;
  logic [31:0] mRegs [0:31];
  logic [31:0] mMem [0:`DMEM_DEPTH-1]; // not cleared by reset, same as the dut

  mipsSystem dut_i (
    .clk       (clk),
    .rst       (rst),
    .instrAddr (instrAddr),
    .instr     (instr),
    .wbValid   (wbValid),
    .wbAddr    (wbAddr),
    .wbData    (wbData)
  );

  bind mipsSystem mipsSystem_props props_i (
    .clk       (clk),
    .rst       (rst),
    .instrAddr (instrAddr),
    .wbValid   (wbValid),
    .wbAddr    (wbAddr),
    .cen       (dmemBus.cen),
    .wen       (dmemBus.wen)
  );

  always #4 clk = ~clk; // 8 ns period

  assign instr = imem[instrAddr[9:2]]; // same-cycle fetch

  // ==================================================
  // reporting and stimulus helpers
  // ==================================================
  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic checkEq(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (expected !== actual) begin
      failRun($sformatf("ERROR %s %s expected %h actual %h", curTest, what, expected, actual));
    end
  endtask

  // galois lfsr, one shift per bit handed out
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsrState[0]};
      lfsrState = {1'b0, lfsrState[31:1]} ^ (lfsrState[0] ? 32'h8020_0003 : 32'h0);
    end
    return v;
  endfunction

  function automatic logic [31:0] encR(input logic [5:0] fn, input logic [4:0] rd,
                                       input logic [4:0] rs, input logic [4:0] rt);
    instrFieldsT f;
    f = '0;
    f.opcode       = opR;
    f.body.r.rs    = rs;
    f.body.r.rt    = rt;
    f.body.r.rd    = rd;
    f.body.r.funct = functT'(fn);
    return f;
  endfunction

  function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rt,
                                       input logic [4:0] rs, input logic [15:0] imm);
    instrFieldsT f;
    f = '0;
    f.opcode     = opcodeT'(op);
    f.body.i.rs  = rs;
    f.body.i.rt  = rt;
    f.body.i.imm = imm;
    return f;
  endfunction

  function automatic logic [31:0] encJ(input logic [5:0] op, input logic [31:0] addr);
    instrFieldsT f;
    f = '0;
    f.opcode      = opcodeT'(op);
    f.body.target = addr[27:2]; // word target
    return f;
  endfunction

  task automatic newProgram(input string name);
    curTest = name;
    progLen = 0;
    for (int i = 0; i < ImemWords; i++) begin
      imem[i] = '0; // funct 0, decodes as no-op
    end
  endtask

  task automatic emit(input logic [31:0] w);
    imem[progLen] = w;
    progLen++;
  endtask

  // ==================================================
  // reference model, one instruction per call
  // ==================================================
  task automatic modelStep(input logic [31:0] w, output logic expV,
                           output logic [4:0] expA, output logic [31:0] expD);
    logic [31:0] rsV;
    logic [31:0] rtV;
    logic [31:0] imm;
    logic [31:0] pc4;
    logic [31:0] nextPc;
    logic        wr;
    rsV    = mRegs[w[25:21]];
    rtV    = mRegs[w[20:16]];
    imm    = {{16{w[15]}}, w[15:0]};
    pc4    = mPc + 32'd4;
    nextPc = pc4;
    wr     = 1'b0;
    expA   = w[20:16]; // rt unless overridden
    expD   = rsV + imm;
    case (w[31:26])
      opR: begin
        wr   = 1'b1;
        expA = w[15:11];
        case (w[5:0])
          fnAdd:   expD = rsV + rtV;
          fnSub:   expD = rsV - rtV;
          fnAnd:   expD = rsV & rtV;
          fnOr:    expD = rsV | rtV;
          fnSlt:   expD = ($signed(rsV) < $signed(rtV)) ? 32'd1 : 32'd0;
          default: wr = 1'b0; // unknown funct
        endcase
      end
      opAddi: wr = 1'b1;
      opLw: begin
        wr   = 1'b1;
        expD = mMem[expD[8:2]];
      end
      opSw: mMem[expD[8:2]] = rtV;
      opBeq: begin
        if (rsV == rtV) begin
          nextPc = pc4 + (imm << 2);
        end
      end
      opJ: nextPc = {pc4[31:28], w[25:0], 2'b00};
      opJal: begin
        nextPc = {pc4[31:28], w[25:0], 2'b00};
        wr     = 1'b1;
        expA   = 5'd31;
        expD   = pc4; // no delay slot
      end
      default: ; // undefined opcode
    endcase
    expV = wr && (expA != 5'd0);
    if (expV) begin
      mRegs[expA] = expD;
    end
    mPc = nextPc;
  endtask

  // ==================================================
  // reset and run loop
  // ==================================================
  task automatic applyReset();
    repeat (4) @(posedge clk); // rst already high here
    #1 rst = 1'b0;
    mPc = `RESET_PC;
    for (int i = 0; i < 32; i++) begin
      mRegs[i] = '0;
    end
  endtask

  task automatic runProgram();
    int          cycles;
    logic        expV;
    logic [4:0]  expA;
    logic [31:0] expD;
    endPc  = 32'(progLen * 4);
    applyReset();
    cycles = 0;
    @(negedge clk); // outputs settled mid-cycle
    while (mPc != endPc) begin
      if (cycles == MaxCycles) begin
        failRun($sformatf("%s did not reach its end address %h", curTest, endPc));
      end
      checkEq("instrAddr", mPc, instrAddr);
      modelStep(imem[mPc[9:2]], expV, expA, expD);
      checkEq("wbValid", 32'(expV), 32'(wbValid));
      if (expV) begin
        checkEq("wbAddr", 32'(expA), 32'(wbAddr));
        checkEq("wbData", expD, wbData);
      end
      cycles++;
      @(negedge clk);
    end
    checkEq("final instrAddr", endPc, instrAddr);
    @(posedge clk);
    #1 rst = 1'b1; // hold the core while the next program loads
  endtask

  // ==================================================
  // directed tests
  // ==================================================
  task automatic testAddi();
    logic [31:0] v;
    newProgram("testAddi");
    v = randBits(15);
    emit(encI(opAddi, 5'd1, 5'd0, v[15:0])); // positive imm
    v = randBits(15) | 32'h0000_8000;
    emit(encI(opAddi, 5'd2, 5'd0, v[15:0])); // negative imm
    v = randBits(16);
    emit(encI(opAddi, 5'd3, 5'd2, v[15:0]));
    emit(encI(opAddi, 5'd0, 5'd1, 16'h0123)); // dropped, no wbValid
    v = randBits(16);
    emit(encI(opAddi, 5'd4, 5'd0, v[15:0])); // r0 still reads zero
    runProgram();
  endtask

  task automatic testRType();
    logic [31:0] v;
    newProgram("testRType");
    v = randBits(15) | 32'h0000_8000;
    emit(encI(opAddi, 5'd1, 5'd0, v[15:0]));
    v = randBits(15);
    emit(encI(opAddi, 5'd2, 5'd0, v[15:0]));
    v = randBits(16);
    emit(encI(opAddi, 5'd3, 5'd0, v[15:0]));
    v = randBits(16);
    emit(encI(opAddi, 5'd4, 5'd0, v[15:0]));
    emit(encR(fnAdd, 5'd5, 5'd1, 5'd2));
    emit(encR(fnSub, 5'd6, 5'd3, 5'd4));
    emit(encR(fnAnd, 5'd7, 5'd1, 5'd3));
    emit(encR(fnOr, 5'd8, 5'd2, 5'd4));
    emit(encR(fnSlt, 5'd9, 5'd1, 5'd2)); // negative vs positive, signed
    emit(encR(fnSlt, 5'd10, 5'd2, 5'd1));
    emit(encR(fnAdd, 5'd11, 5'd5, 5'd6));
    runProgram();
  endtask

  task automatic testMemory();
    logic [31:0] v;
    newProgram("testMemory");
    for (int i = 1; i <= 3; i++) begin
      v = randBits(16);
      emit(encI(opAddi, 5'(i), 5'd0, v[15:0]));
    end
    emit(encI(opAddi, 5'd10, 5'd0, 16'h0040)); // base, word 16
    emit(encI(opSw, 5'd1, 5'd10, 16'h0000));
    emit(encI(opSw, 5'd2, 5'd10, 16'h0004));
    emit(encI(opSw, 5'd3, 5'd10, 16'hfffc)); // word 15
    emit(encI(opLw, 5'd4, 5'd10, 16'h0000));
    emit(encI(opLw, 5'd5, 5'd10, 16'h0004));
    emit(encI(opLw, 5'd6, 5'd10, 16'hfffc));
    emit(encI(opLw, 5'd7, 5'd0, 16'h01f0)); // word 124, never written
    runProgram();
  endtask

  task automatic testBranch();
    logic [31:0] v;
    newProgram("testBranch");
    v = randBits(16);
    emit(encI(opAddi, 5'd1, 5'd0, v[15:0]));
    emit(encI(opAddi, 5'd2, 5'd0, v[15:0]));
    emit(encI(opAddi, 5'd3, 5'd1, 16'h0001));
    emit(encI(opBeq, 5'd2, 5'd1, 16'h0001)); // equal, skips one
    emit(encI(opAddi, 5'd4, 5'd0, 16'h0011));
    emit(encI(opBeq, 5'd3, 5'd1, 16'h0001)); // unequal, falls through
    emit(encI(opAddi, 5'd5, 5'd0, 16'h0022));
    emit(encI(opBeq, 5'd0, 5'd0, 16'h0002)); // skips two
    emit(encI(opAddi, 5'd6, 5'd0, 16'h0033));
    emit(encI(opAddi, 5'd7, 5'd0, 16'h0044));
    emit(encI(opAddi, 5'd9, 5'd0, 16'h0003));
    emit(encI(opAddi, 5'd9, 5'd9, 16'hffff)); // countdown loop top
    emit(encI(opBeq, 5'd0, 5'd9, 16'h0001));
    emit(encI(opBeq, 5'd0, 5'd0, 16'hfffd)); // backward, to loop top
    runProgram();
  endtask

  task automatic testJump();
    newProgram("testJump");
    emit(encI(opAddi, 5'd1, 5'd0, 16'h0001));
    emit(encJ(opJ, 32'd16));
    emit(encI(opAddi, 5'd2, 5'd0, 16'h0002));
    emit(encI(opAddi, 5'd3, 5'd0, 16'h0003));
    emit(encJ(opJal, 32'd28)); // r31 gets 20
    emit(encI(opAddi, 5'd4, 5'd0, 16'h0004));
    emit(encI(opAddi, 5'd5, 5'd0, 16'h0005));
    emit(encI(opAddi, 5'd6, 5'd31, 16'h0004)); // reads link value
    runProgram();
  endtask

  task automatic testIllegal();
    logic [31:0] v;
    newProgram("testIllegal");
    v = randBits(16);
    emit(encI(opAddi, 5'd1, 5'd0, v[15:0]));
    emit(encI(opAddi, 5'd3, 5'd1, 16'h0001)); // always differs from r1
    emit(encI(opAddi, 5'd2, 5'd0, 16'h0080)); // base, word 32
    emit(encI(opSw, 5'd1, 5'd2, 16'h0000));
    emit(encI(6'h28, 5'd3, 5'd2, 16'h0000)); // sb slot, not in the subset
    emit(encI(6'h3f, 5'd5, 5'd1, 16'h0000));
    emit(encR(6'h3f, 5'd6, 5'd1, 5'd3));
    emit(encR(6'h00, 5'd7, 5'd1, 5'd3)); // sll slot
    emit(encI(opLw, 5'd8, 5'd2, 16'h0000)); // still r1
    runProgram();
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    for (int i = 0; i < `DMEM_DEPTH; i++) begin
      mMem[i] = '0;
    end
    newProgram("idle");
    testAddi();
    testRType();
    testMemory();
    testBranch();
    testJump();
    testIllegal();
    if (dut_i.props_i.failCount != 0) begin
      failRun("a bound assertion on the DUT failed");
    end else begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

//--- compile.f
+incdir+hw
hw/mipsIsaPkg.sv
hw/mipsCtrlPkg.sv
hw/dmemIf.sv
hw/controlUnit.sv
hw/alu.sv
hw/regFile.sv
hw/dataMem.sv
hw/mipsCore.sv
hw/mipsSystem.sv
test/mipsSystem_props.sv
test/mipsSystem_tb.sv

//--- Makefile
TOP := mipsSystem_tb
OBJ := obj_dir

all: run

build:
	verilator --binary --timing --assert -j 0 -f compile.f --top-module $(TOP) -Mdir $(OBJ)

run: build
	./$(OBJ)/V$(TOP) +verilator+error+limit+100

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

clean:
	rm -rf $(OBJ)

.PHONY: all build run lint clean
